// ==== mips_pkg.sv ====
package mips_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int OP_W       = 6;

	// Primary opcodes
	localparam logic [OP_W-1:0] OP_RTYPE  = 6'b000000;
	localparam logic [OP_W-1:0] OP_REGIMM = 6'b000001;
	localparam logic [OP_W-1:0] OP_J      = 6'b000010;
	localparam logic [OP_W-1:0] OP_JAL    = 6'b000011;
	localparam logic [OP_W-1:0] OP_BEQ    = 6'b000100;
	localparam logic [OP_W-1:0] OP_BNE    = 6'b000101;
	localparam logic [OP_W-1:0] OP_BLEZ   = 6'b000110;
	localparam logic [OP_W-1:0] OP_BGTZ   = 6'b000111;
	localparam logic [OP_W-1:0] OP_ADDI   = 6'b001000;
	localparam logic [OP_W-1:0] OP_ADDIU  = 6'b001001;
	localparam logic [OP_W-1:0] OP_SLTI   = 6'b001010;
	localparam logic [OP_W-1:0] OP_SLTIU  = 6'b001011;
	localparam logic [OP_W-1:0] OP_ORI    = 6'b001101;
	localparam logic [OP_W-1:0] OP_XORI   = 6'b001110;
	localparam logic [OP_W-1:0] OP_LUI    = 6'b001111;
	localparam logic [OP_W-1:0] OP_MUL    = 6'b011100; // SPECIAL2
	localparam logic [OP_W-1:0] OP_LB     = 6'b100000;
	localparam logic [OP_W-1:0] OP_LW     = 6'b100011;
	localparam logic [OP_W-1:0] OP_LBU    = 6'b100100;
	localparam logic [OP_W-1:0] OP_SB     = 6'b101000;
	localparam logic [OP_W-1:0] OP_SW     = 6'b101011;

	// Function codes
	localparam logic [OP_W-1:0] FN_SLL   = 6'b000000;
	localparam logic [OP_W-1:0] FN_SRL   = 6'b000010;
	localparam logic [OP_W-1:0] FN_MUL   = 6'b000010; // Under OP_MUL only
	localparam logic [OP_W-1:0] FN_SRA   = 6'b000011;
	localparam logic [OP_W-1:0] FN_SLLV  = 6'b000100;
	localparam logic [OP_W-1:0] FN_SRLV  = 6'b000110;
	localparam logic [OP_W-1:0] FN_SRAV  = 6'b000111;
	localparam logic [OP_W-1:0] FN_JR    = 6'b001000;
	localparam logic [OP_W-1:0] FN_JALR  = 6'b001001;
	localparam logic [OP_W-1:0] FN_MFHI  = 6'b010000;
	localparam logic [OP_W-1:0] FN_MFLO  = 6'b010010;
	localparam logic [OP_W-1:0] FN_MULT  = 6'b011000;
	localparam logic [OP_W-1:0] FN_MULTU = 6'b011001;
	localparam logic [OP_W-1:0] FN_DIV   = 6'b011010;
	localparam logic [OP_W-1:0] FN_DIVU  = 6'b011011;
	localparam logic [OP_W-1:0] FN_ADD   = 6'b100000;
	localparam logic [OP_W-1:0] FN_ADDU  = 6'b100001;
	localparam logic [OP_W-1:0] FN_SUB   = 6'b100010;
	localparam logic [OP_W-1:0] FN_SUBU  = 6'b100011;
	localparam logic [OP_W-1:0] FN_AND   = 6'b100100;
	localparam logic [OP_W-1:0] FN_OR    = 6'b100101;
	localparam logic [OP_W-1:0] FN_XOR   = 6'b100110;
	localparam logic [OP_W-1:0] FN_NOR   = 6'b100111;
	localparam logic [OP_W-1:0] FN_SLT   = 6'b101010;
	localparam logic [OP_W-1:0] FN_SLTU  = 6'b101011;

	// REGIMM codes live in the rt field
	localparam logic [REG_ADDR_W-1:0] RI_BLTZ = 5'b00000;
	localparam logic [REG_ADDR_W-1:0] RI_BGEZ = 5'b00001;

	typedef struct packed {
		logic [OP_W-1:0]       opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] sa;
		logic [OP_W-1:0]       func;
	} r_fields_t;

	typedef struct packed {
		logic [OP_W-1:0]       opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [15:0]           imm16;
	} i_fields_t;

	typedef struct packed {
		logic [OP_W-1:0] opcode;
		logic [25:0]     target26;
	} j_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} insn_u;

	typedef enum logic [2:0] {
		KIND_NOP     = 3'd0,
		KIND_R       = 3'd1,
		KIND_I       = 3'd2,
		KIND_REGIMM  = 3'd3,
		KIND_J       = 3'd4,
		KIND_ILLEGAL = 3'd5
	} insn_kind_e;

	typedef struct packed {
		insn_kind_e            kind;
		logic [OP_W-1:0]       op;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] sa;
		logic [DATA_W-1:0]     imm;
	} dec_t;

	typedef struct packed {
		logic                  we;
		logic [REG_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     data;
	} wb_t;

endpackage

// ==== insn_decoder.sv ====
module insn_decoder (
	input  mips_pkg::insn_u insn,
	output mips_pkg::dec_t  dec
);

	logic                         r_known;
	logic [mips_pkg::DATA_W-1:0] imm_sx;
	logic [mips_pkg::DATA_W-1:0] target_zx;

	assign imm_sx    = {{16{insn.i.imm16[15]}}, insn.i.imm16};
	assign target_zx = {6'b0, insn.j.target26};

	always_comb begin
		case (insn.r.func)
			mips_pkg::FN_ADD,  mips_pkg::FN_ADDU, mips_pkg::FN_SUB,  mips_pkg::FN_SUBU,
			mips_pkg::FN_MULT, mips_pkg::FN_MULTU, mips_pkg::FN_DIV, mips_pkg::FN_DIVU,
			mips_pkg::FN_MFHI, mips_pkg::FN_MFLO, mips_pkg::FN_SLT,  mips_pkg::FN_SLTU,
			mips_pkg::FN_SLL,  mips_pkg::FN_SLLV, mips_pkg::FN_SRL,  mips_pkg::FN_SRLV,
			mips_pkg::FN_SRA,  mips_pkg::FN_SRAV, mips_pkg::FN_AND,  mips_pkg::FN_OR,
			mips_pkg::FN_XOR,  mips_pkg::FN_NOR,  mips_pkg::FN_JR,   mips_pkg::FN_JALR:
				r_known = 1'b1;
			default:
				r_known = 1'b0;
		endcase
	end

	always_comb begin
		dec = '0;
		dec.kind = mips_pkg::KIND_ILLEGAL; // Overridden below for known codes
		if (insn == '0) begin
			dec.kind = mips_pkg::KIND_NOP;
		end else begin
			case (insn.r.opcode)
				mips_pkg::OP_RTYPE: begin
					if (r_known) begin
						dec.kind = mips_pkg::KIND_R;
						dec.op   = insn.r.func;
						dec.rs   = insn.r.rs;
						dec.rt   = insn.r.rt;
						dec.rd   = insn.r.rd;
						case (insn.r.func)
							mips_pkg::FN_MULT, mips_pkg::FN_MULTU,
							mips_pkg::FN_DIV, mips_pkg::FN_DIVU: begin
								dec.rd = '0; // Result goes to HI/LO
							end
							mips_pkg::FN_JR: begin
								dec.rt = '0;
								dec.rd = '0;
							end
							mips_pkg::FN_MFHI, mips_pkg::FN_MFLO: begin
								dec.rs = '0;
								dec.rt = '0;
							end
							mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
								dec.rs = '0;
								dec.sa = insn.r.sa; // Constant shift amount
							end
							default: ;
						endcase
					end
				end
				mips_pkg::OP_MUL: begin
					if (insn.r.func == mips_pkg::FN_MUL) begin
						dec.kind = mips_pkg::KIND_R;
						dec.op   = insn.r.func;
						dec.rs   = insn.r.rs;
						dec.rt   = insn.r.rt;
						dec.rd   = insn.r.rd;
					end
				end
				mips_pkg::OP_REGIMM: begin
					if (insn.i.rt == mips_pkg::RI_BLTZ || insn.i.rt == mips_pkg::RI_BGEZ) begin
						dec.kind = mips_pkg::KIND_REGIMM;
						dec.op   = {1'b0, insn.i.rt};
						dec.rs   = insn.i.rs;
						dec.rt   = insn.i.rt;
						dec.imm  = imm_sx;
					end
				end
				mips_pkg::OP_J, mips_pkg::OP_JAL: begin
					dec.kind = mips_pkg::KIND_J;
					dec.op   = insn.j.opcode;
					dec.imm  = target_zx;
				end
				mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
				mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LW, mips_pkg::OP_LB,
				mips_pkg::OP_LBU, mips_pkg::OP_LUI: begin
					dec.kind = mips_pkg::KIND_I;
					dec.op   = insn.i.opcode;
					dec.rs   = (insn.i.opcode == mips_pkg::OP_LUI) ? '0 : insn.i.rs;
					dec.rt   = insn.i.rt;
					dec.rd   = insn.i.rt; // Writes back to rt
					dec.imm  = imm_sx;
				end
				mips_pkg::OP_SW, mips_pkg::OP_SB, mips_pkg::OP_BEQ, mips_pkg::OP_BNE,
				mips_pkg::OP_BGTZ, mips_pkg::OP_BLEZ: begin
					dec.kind = mips_pkg::KIND_I;
					dec.op   = insn.i.opcode;
					dec.rs   = insn.i.rs;
					dec.rt   = insn.i.rt;
					dec.imm  = imm_sx; // No destination register
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== decode_stage.sv ====
module decode_stage (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        decode_en,
	input  logic [mips_pkg::DATA_W-1:0] pc,
	input  mips_pkg::insn_u             insn,
	output logic [mips_pkg::DATA_W-1:0] pc_q,
	output logic [mips_pkg::DATA_W-1:0] insn_q,
	output mips_pkg::dec_t              dec
);

	mips_pkg::dec_t dec_d;

	insn_decoder u_insn_decoder (
		.insn (insn),
		.dec  (dec_d)
	);

	// Fetch to execute pipeline register
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc_q   <= '0;
			insn_q <= '0;
			dec    <= '0; // Kind NOP
		end else if (decode_en) begin
			pc_q   <= pc;
			insn_q <= insn;
			dec    <= dec_d;
		end
	end

endmodule

// ==== reg_file.sv ====
module reg_file (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
	input  mips_pkg::wb_t                   wb,
	output logic [mips_pkg::DATA_W-1:0]     rs_val,
	output logic [mips_pkg::DATA_W-1:0]     rt_val
);

	logic [mips_pkg::DATA_W-1:0] regs [mips_pkg::NUM_REGS];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
				regs[i] <= i[mips_pkg::DATA_W-1:0]; // Register i holds i
			end
		end else if (wb.we) begin
			regs[wb.addr] <= wb.data; // r0 is an ordinary register here
		end
	end

	// Reads see the old value during a write cycle
	assign rs_val = regs[rs_addr];
	assign rt_val = regs[rt_addr];

endmodule

// ==== decode_top.sv ====
module decode_top (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        decode_en,
	input  logic [mips_pkg::DATA_W-1:0] pc,
	input  logic [mips_pkg::DATA_W-1:0] insn,
	input  mips_pkg::wb_t               wb,
	output logic [mips_pkg::DATA_W-1:0] pc_q,
	output logic [mips_pkg::DATA_W-1:0] insn_q,
	output mips_pkg::dec_t              dec,
	output logic [mips_pkg::DATA_W-1:0] rs_val,
	output logic [mips_pkg::DATA_W-1:0] rt_val
);

	decode_stage u_decode_stage (
		.clock     (clock),
		.arst_n    (arst_n),
		.decode_en (decode_en),
		.pc        (pc),
		.insn      (insn),
		.pc_q      (pc_q),
		.insn_q    (insn_q),
		.dec       (dec)
	);

	// Operand reads use the registered fields
	reg_file u_reg_file (
		.clock   (clock),
		.arst_n  (arst_n),
		.rs_addr (dec.rs),
		.rt_addr (dec.rt),
		.wb      (wb),
		.rs_val  (rs_val),
		.rt_val  (rt_val)
	);

endmodule

// ==== tb_clock.sv ====
module tb_clock (
	output logic clock,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (16) @(negedge clock);
		arst_n = 1'b1; // Released away from the rising edge
	end

endmodule

// ==== tb_decode.sv ====
module tb_decode;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_TIMEOUT = 100;
	localparam int N_RAND        = 200;

	logic                        clock;
	logic                        arst_n;
	logic                        decode_en;
	logic [mips_pkg::DATA_W-1:0] pc;
	logic [mips_pkg::DATA_W-1:0] insn;
	mips_pkg::wb_t               wb;
	logic [mips_pkg::DATA_W-1:0] pc_q;
	logic [mips_pkg::DATA_W-1:0] insn_q;
	mips_pkg::dec_t              dec;
	logic [mips_pkg::DATA_W-1:0] rs_val;
	logic [mips_pkg::DATA_W-1:0] rt_val;

	logic [mips_pkg::DATA_W-1:0] exp_pc;
	logic [mips_pkg::DATA_W-1:0] exp_insn;
	mips_pkg::dec_t              exp_dec;
	logic [mips_pkg::DATA_W-1:0] model_regs [mips_pkg::NUM_REGS];
	int                          n_pass;
	int                          n_fail;
	int                          test_base; // Failures before the current test

	tb_clock u_clock (.*);

	decode_top dut (.*);

	function automatic mips_pkg::dec_t model_decode(input mips_pkg::insn_u w);
		mips_pkg::dec_t  d;
		logic [5:0]      fn;
		logic [5:0]      opc;
		logic            r_ok;
		d    = '0;
		fn   = w.r.func;
		opc  = w.r.opcode;
		r_ok = fn inside {mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
			mips_pkg::FN_SUBU, mips_pkg::FN_MULT, mips_pkg::FN_MULTU, mips_pkg::FN_DIV,
			mips_pkg::FN_DIVU, mips_pkg::FN_MFHI, mips_pkg::FN_MFLO, mips_pkg::FN_SLT,
			mips_pkg::FN_SLTU, mips_pkg::FN_SLL, mips_pkg::FN_SLLV, mips_pkg::FN_SRL,
			mips_pkg::FN_SRLV, mips_pkg::FN_SRA, mips_pkg::FN_SRAV, mips_pkg::FN_AND,
			mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_JR,
			mips_pkg::FN_JALR};
		if (w == '0) begin
			d.kind = mips_pkg::KIND_NOP;
		end else if ((opc == mips_pkg::OP_RTYPE && r_ok) ||
				(opc == mips_pkg::OP_MUL && fn == mips_pkg::FN_MUL)) begin
			d.kind = mips_pkg::KIND_R;
			d.op   = fn;
			d.rs   = w.r.rs;
			d.rt   = w.r.rt;
			d.rd   = w.r.rd;
			if (opc == mips_pkg::OP_RTYPE) begin // SPECIAL2 MUL keeps all three
				if (fn inside {mips_pkg::FN_MULT, mips_pkg::FN_MULTU, mips_pkg::FN_DIV,
						mips_pkg::FN_DIVU, mips_pkg::FN_JR})
					d.rd = '0;
				if (fn == mips_pkg::FN_JR)
					d.rt = '0;
				if (fn inside {mips_pkg::FN_MFHI, mips_pkg::FN_MFLO}) begin
					d.rs = '0;
					d.rt = '0;
				end
				if (fn inside {mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA}) begin
					d.rs = '0;
					d.sa = w.r.sa;
				end
			end
		end else if (opc == mips_pkg::OP_REGIMM &&
				w.i.rt inside {mips_pkg::RI_BLTZ, mips_pkg::RI_BGEZ}) begin
			d.kind = mips_pkg::KIND_REGIMM;
			d.op   = {1'b0, w.i.rt};
			d.rs   = w.i.rs;
			d.rt   = w.i.rt;
			d.imm  = {{16{w.i.imm16[15]}}, w.i.imm16};
		end else if (opc inside {mips_pkg::OP_J, mips_pkg::OP_JAL}) begin
			d.kind = mips_pkg::KIND_J;
			d.op   = opc;
			d.imm  = {6'b0, w.j.target26};
		end else if (opc inside {mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
				mips_pkg::OP_SLTIU, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LW,
				mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LUI, mips_pkg::OP_SW,
				mips_pkg::OP_SB, mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BGTZ,
				mips_pkg::OP_BLEZ}) begin
			d.kind = mips_pkg::KIND_I;
			d.op   = opc;
			d.rs   = (opc == mips_pkg::OP_LUI) ? '0 : w.i.rs;
			d.rt   = w.i.rt;
			d.rd   = (opc inside {mips_pkg::OP_SW, mips_pkg::OP_SB, mips_pkg::OP_BEQ,
				mips_pkg::OP_BNE, mips_pkg::OP_BGTZ, mips_pkg::OP_BLEZ}) ? '0 : w.i.rt;
			d.imm  = {{16{w.i.imm16[15]}}, w.i.imm16};
		end else begin
			d.kind = mips_pkg::KIND_ILLEGAL;
		end
		return d;
	endfunction

	// Draws words until the model classifies one as the wanted kind
	function automatic mips_pkg::insn_u rand_word(input mips_pkg::insn_kind_e kind);
		mips_pkg::insn_u w;
		mips_pkg::dec_t  d;
		int              tries;
		tries = 0;
		do begin
			w = $urandom;
			case ($urandom_range(7, 0)) // Bias toward opcodes with sub-codes
				0, 1, 2: w.r.opcode = mips_pkg::OP_RTYPE;
				3: begin
					w.r.opcode    = mips_pkg::OP_MUL;
					w.r.func[5:2] = '0;
				end
				4: w.i.opcode = mips_pkg::OP_REGIMM;
				5: begin
					w.i.opcode = mips_pkg::OP_REGIMM;
					w.i.rt     = {4'b0, w.i.rt[0]};
				end
				default: ;
			endcase
			d = model_decode(w);
			tries++;
		end while (d.kind != kind && tries < 1000);
		return w;
	endfunction

	function automatic mips_pkg::insn_u read_word(input logic [4:0] rs, input logic [4:0] rt);
		mips_pkg::insn_u w;
		w.r.opcode = mips_pkg::OP_RTYPE;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = 5'($urandom);
		w.r.sa     = '0;
		w.r.func   = mips_pkg::FN_ADD; // Reads both operands
		return w;
	endfunction

	function automatic mips_pkg::wb_t idle_wb();
		mips_pkg::wb_t v;
		v.we   = 1'b0;
		v.addr = 5'($urandom); // Must be ignored
		v.data = $urandom;
		return v;
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		if (act_v !== exp_v) begin
			$display("FAILED %s: expected %h, got %h at %0t", name, exp_v, act_v, $time);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic check_outputs();
		check_val("pc_q", 64'(exp_pc), 64'(pc_q));
		check_val("insn_q", 64'(exp_insn), 64'(insn_q));
		check_val("dec", 64'(exp_dec), 64'(dec));
		check_val("rs_val", 64'(model_regs[exp_dec.rs]), 64'(rs_val));
		check_val("rt_val", 64'(model_regs[exp_dec.rt]), 64'(rt_val));
	endtask

	// Called on a falling edge; checks at the next falling edge
	task automatic step(input logic en, input logic [31:0] new_pc,
			input mips_pkg::insn_u new_insn, input mips_pkg::wb_t new_wb);
		decode_en = en;
		pc        = new_pc;
		insn      = new_insn;
		wb        = new_wb;
		@(posedge clock);
		if (en) begin
			exp_pc   = new_pc;
			exp_insn = new_insn;
			exp_dec  = model_decode(new_insn);
		end
		if (new_wb.we)
			model_regs[new_wb.addr] = new_wb.data;
		@(negedge clock);
		check_outputs();
	endtask

	task automatic wait_reset_release(output logic ok);
		int cycles;
		cycles = 0;
		while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		ok = (arst_n === 1'b1);
		@(negedge clock);
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished with %0d errors", name, n_fail - test_base);
		test_base = n_fail;
	endtask

	initial begin
		logic          reset_ok;
		mips_pkg::wb_t wr;
		void'($urandom(92865));
		n_pass    = 0;
		n_fail    = 0;
		test_base = 0;
		decode_en = 1'b0;
		pc        = '0;
		insn      = '0;
		wb        = '0;
		exp_pc    = '0;
		exp_insn  = '0;
		exp_dec   = '0;
		for (int i = 0; i < mips_pkg::NUM_REGS; i++)
			model_regs[i] = i;
		wait_reset_release(reset_ok);
		if (!reset_ok) begin
			$display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
			n_fail++;
		end else begin
			check_outputs();
			end_test("reset state");
			repeat (N_RAND) step(1'b1, $urandom, rand_word(mips_pkg::KIND_R), idle_wb());
			end_test("R-type decode");
			repeat (N_RAND) begin
				step(1'b1, $urandom, rand_word(mips_pkg::KIND_I), idle_wb());
				step(1'b1, $urandom, rand_word(mips_pkg::KIND_REGIMM), idle_wb());
				step(1'b1, $urandom, rand_word(mips_pkg::KIND_J), idle_wb());
			end
			end_test("I-type, REGIMM and J-type decode");
			step(1'b1, $urandom, '0, idle_wb());
			repeat (N_RAND) begin
				step(1'b1, $urandom, rand_word(mips_pkg::KIND_I), idle_wb());
				step(1'b1, $urandom, rand_word(mips_pkg::KIND_ILLEGAL), idle_wb());
			end
			step(1'b1, $urandom, '0, idle_wb());
			end_test("NOP and illegal");
			repeat (20) begin
				step(1'b1, $urandom, rand_word(mips_pkg::KIND_R), idle_wb());
				repeat ($urandom_range(8, 2)) step(1'b0, $urandom, $urandom, idle_wb());
			end
			end_test("hold");
			repeat (32) step(1'b1, $urandom, read_word(5'($urandom), 5'($urandom)), idle_wb());
			repeat (64) begin
				wr.we   = 1'b1;
				wr.addr = 5'($urandom);
				wr.data = $urandom;
				step(1'b0, $urandom, $urandom, wr);
				step(1'b1, $urandom, read_word(wr.addr, 5'($urandom)), idle_wb());
				wr = idle_wb();
				step(1'b0, $urandom, $urandom, wr);
				step(1'b1, $urandom, read_word(5'($urandom), wr.addr), idle_wb());
			end
			end_test("register file");
		end
		$display("Checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
mips_pkg.sv
insn_decoder.sv
decode_stage.sv
reg_file.sv
decode_top.sv
tb_clock.sv
tb_decode.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_decode \
		-f flist.f -o tb_decode

run: compile
	@out="$$(./obj_dir/tb_decode)"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir
